// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////////////////////////

    // Data and address width
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // Fetch steps one word at a time
    localparam logic [xlen-1:0] instr_step = 32'd4;
    localparam logic [xlen-1:0] reset_pc   = 32'h0000_0000;

    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr  = 32'h0000_0013;

    ////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // Major opcodes still recognized by the decoder
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        branch = 7'b1100011,
        jal    = 7'b1101111
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // Control encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        and_op = 4'd2,
        or_op  = 4'd3,
        xor_op = 4'd4,
        slt    = 4'd5,
        sltu   = 4'd6,
        sll    = 4'd7,
        srl    = 4'd8,
        sra    = 4'd9
    } alu_func_e;

    // Jump is the unconditional case
    typedef enum logic [2:0] {
        none = 3'd0,
        beq  = 3'd1,
        bne  = 3'd2,
        blt  = 3'd3,
        bge  = 3'd4,
        bltu = 3'd5,
        bgeu = 3'd6,
        jump = 3'd7
    } br_func_e;

    // Zero feeds operand a for LUI
    typedef enum logic {
        rs1  = 1'b0,
        zero = 1'b1
    } op1_sel_e;

    typedef enum logic {
        rs2 = 1'b0,
        imm = 1'b1
    } op2_sel_e;

    // Link value for JAL
    typedef enum logic {
        alu = 1'b0,
        pc4 = 1'b1
    } wb_sel_e;

endpackage

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input  rv_core_pkg::word_t     instr,
    output rv_core_pkg::reg_idx_t  rs1,
    output rv_core_pkg::reg_idx_t  rs2,
    output rv_core_pkg::reg_idx_t  rd,
    output rv_core_pkg::word_t     imm,
    output rv_core_pkg::alu_func_e alu_func,
    output rv_core_pkg::br_func_e  br_func,
    output rv_core_pkg::op1_sel_e  op1_sel,
    output rv_core_pkg::op2_sel_e  op2_sel,
    output rv_core_pkg::wb_sel_e   wb_sel,
    output logic                   use_rs1,
    output logic                   use_rs2,
    output logic                   werf
);
    import rv_core_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic        alt;
    word_t       imm_i;
    word_t       imm_u;
    word_t       imm_b;
    word_t       imm_j;

    // funct3 picks the operation, bit 30 picks SUB and SRA
    function automatic alu_func_e alu_from_funct3(input logic [2:0] f3,
                                                  input logic sub_ok,
                                                  input logic f7_alt);
        case (f3)
            3'b000:  return (sub_ok && f7_alt) ? sub : add;
            3'b001:  return sll;
            3'b010:  return slt;
            3'b011:  return sltu;
            3'b100:  return xor_op;
            3'b101:  return f7_alt ? sra : srl;
            3'b110:  return or_op;
            default: return and_op;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        imm      = '0;
        alu_func = add;
        br_func  = none;
        op1_sel  = rv_core_pkg::rs1;
        op2_sel  = rv_core_pkg::rs2;
        wb_sel   = alu;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        werf     = 1'b0;
        case (opcode)
            op: begin
                alu_func = alu_from_funct3(funct3, 1'b1, alt);
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                werf     = 1'b1;
            end
            op_imm: begin
                alu_func = alu_from_funct3(funct3, 1'b0, alt);
                imm      = imm_i;
                op2_sel  = rv_core_pkg::imm;
                use_rs1  = 1'b1;
                werf     = 1'b1;
            end
            lui: begin
                imm     = imm_u;
                op1_sel = zero;
                op2_sel = rv_core_pkg::imm;
                werf    = 1'b1;
            end
            branch: begin
                imm     = imm_b;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  br_func = beq;
                    3'b001:  br_func = bne;
                    3'b100:  br_func = blt;
                    3'b101:  br_func = bge;
                    3'b110:  br_func = bltu;
                    3'b111:  br_func = bgeu;
                    default: br_func = none;
                endcase
            end
            jal: begin
                imm     = imm_j;
                br_func = jump;
                wb_sel  = pc4;
                werf    = 1'b1;
            end
            // Everything else retires as a no-op
            default: ;
        endcase
        // x0 is never a real destination
        if (rd == '0) begin
            werf = 1'b0;
        end
    end

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  rv_core_pkg::reg_idx_t ra,
    input  rv_core_pkg::reg_idx_t rb,
    output rv_core_pkg::word_t    rd1,
    output rv_core_pkg::word_t    rd2,
    input  rv_core_pkg::reg_idx_t wa,
    input  rv_core_pkg::word_t    wd,
    input  logic                  we
);
    import rv_core_pkg::*;

    word_t regs [num_regs];

    // Entry zero is never written after reset
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous read ports
    assign rd1 = regs[ra];
    assign rd2 = regs[rb];

    a_x0_reads_zero: assert property (@(posedge clk_in) disable iff (rst_in)
        (ra == '0 |-> rd1 == '0) and (rb == '0 |-> rd2 == '0))
        else $error("read of x0 returned a nonzero value");

endmodule

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  rv_core_pkg::alu_func_e alu_func,
    input  rv_core_pkg::br_func_e  br_func,
    input  rv_core_pkg::word_t     a,
    input  rv_core_pkg::word_t     b,
    output rv_core_pkg::word_t     result,
    output logic                   br_taken
);
    import rv_core_pkg::*;

    logic [$clog2(xlen)-1:0] shamt;
    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;

    // Shift amount is the low bits of b only
    assign shamt = b[$clog2(xlen)-1:0];

    // Shared comparisons for SLT and the branches
    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (alu_func)
            add:     result = a + b;
            sub:     result = a - b;
            and_op:  result = a & b;
            or_op:   result = a | b;
            xor_op:  result = a ^ b;
            slt:     result = {{(xlen-1){1'b0}}, lt_s};
            sltu:    result = {{(xlen-1){1'b0}}, lt_u};
            sll:     result = a << shamt;
            srl:     result = a >> shamt;
            sra:     result = $signed(a) >>> shamt;
            default: result = '0;
        endcase
    end

    always_comb begin
        case (br_func)
            beq:     br_taken = eq;
            bne:     br_taken = !eq;
            blt:     br_taken = lt_s;
            bge:     br_taken = !lt_s;
            bltu:    br_taken = lt_u;
            bgeu:    br_taken = !lt_u;
            jump:    br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

// ==== hdl/rv_forward_unit.sv ====
`timescale 1ns/1ps

module rv_forward_unit (
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    input  logic                  use_rs1,
    input  logic                  use_rs2,
    input  rv_core_pkg::word_t    rf_rd1,
    input  rv_core_pkg::word_t    rf_rd2,
    input  rv_core_pkg::reg_idx_t ex_rd,
    input  logic                  ex_werf,
    input  rv_core_pkg::word_t    ex_value,
    input  rv_core_pkg::reg_idx_t wb_rd,
    input  logic                  wb_werf,
    input  rv_core_pkg::word_t    wb_value,
    output rv_core_pkg::word_t    rs1_value,
    output rv_core_pkg::word_t    rs2_value
);
    import rv_core_pkg::*;

    logic hit1_ex, hit1_wb;
    logic hit2_ex, hit2_wb;

    // Youngest producer wins
    function automatic word_t pick(input logic ex_hit, input logic wb_hit,
                                   input word_t rf_value);
        if (ex_hit) return ex_value;
        if (wb_hit) return wb_value;
        return rf_value;
    endfunction

    assign hit1_ex = use_rs1 && rs1 != '0 && ex_werf && ex_rd == rs1;
    assign hit1_wb = use_rs1 && rs1 != '0 && wb_werf && wb_rd == rs1;
    assign hit2_ex = use_rs2 && rs2 != '0 && ex_werf && ex_rd == rs2;
    assign hit2_wb = use_rs2 && rs2 != '0 && wb_werf && wb_rd == rs2;

    assign rs1_value = pick(hit1_ex, hit1_wb, rf_rd1);
    assign rs2_value = pick(hit2_ex, hit2_wb, rf_rd2);

    // An x0 source always resolves to zero
    always_comb begin
        assert final (!(use_rs1 && rs1 == '0 && rs1_value != '0) &&
                      !(use_rs2 && rs2 == '0 && rs2_value != '0))
            else $error("nonzero value selected for an x0 source");
    end

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  rv_core_pkg::word_t    imem_data,
    output rv_core_pkg::word_t    imem_addr,
    output logic                  wb_valid,
    output rv_core_pkg::reg_idx_t wb_rd,
    output rv_core_pkg::word_t    wb_data
);
    import rv_core_pkg::*;

    word_t     pc;

    // Decode stage
    word_t     id_pc;
    word_t     id_instr;
    reg_idx_t  id_rs1, id_rs2, id_rd;
    word_t     id_imm;
    alu_func_e id_alu_func;
    br_func_e  id_br_func;
    op1_sel_e  id_op1_sel;
    op2_sel_e  id_op2_sel;
    wb_sel_e   id_wb_sel;
    logic      id_use_rs1, id_use_rs2;
    logic      id_werf;
    word_t     id_rf_rd1, id_rf_rd2;
    word_t     id_rs1_value, id_rs2_value;
    word_t     id_operand_a, id_operand_b;

    // Execute stage
    word_t     ex_pc;
    word_t     ex_br_target;
    reg_idx_t  ex_rd;
    word_t     ex_a, ex_b;
    alu_func_e ex_alu_func;
    br_func_e  ex_br_func;
    wb_sel_e   ex_wb_sel;
    logic      ex_werf;
    word_t     ex_alu_result;
    logic      ex_br_taken;
    word_t     ex_value;

    logic      annul;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    // A taken branch or jump sitting in execute squashes fetch and decode
    assign annul     = ex_br_taken;
    assign imem_addr = pc;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc <= reset_pc;
        end else if (annul) begin
            pc <= ex_br_target;
        end else begin
            pc <= pc + instr_step;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in || annul) begin
            id_instr <= nop_instr;
        end else begin
            id_instr <= imem_data;
        end
        id_pc <= pc;
    end

    rv_decoder u_decoder (
        .instr(id_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
        .alu_func(id_alu_func), .br_func(id_br_func), .op1_sel(id_op1_sel),
        .op2_sel(id_op2_sel), .wb_sel(id_wb_sel), .use_rs1(id_use_rs1),
        .use_rs2(id_use_rs2), .werf(id_werf)
    );

    rv_regfile u_regfile (
        .clk_in(clk_in), .rst_in(rst_in), .ra(id_rs1), .rb(id_rs2),
        .rd1(id_rf_rd1), .rd2(id_rf_rd2), .wa(wb_rd), .wd(wb_data), .we(wb_valid)
    );

    rv_forward_unit u_forward (
        .rs1(id_rs1), .rs2(id_rs2), .use_rs1(id_use_rs1), .use_rs2(id_use_rs2),
        .rf_rd1(id_rf_rd1), .rf_rd2(id_rf_rd2),
        .ex_rd(ex_rd), .ex_werf(ex_werf), .ex_value(ex_value),
        .wb_rd(wb_rd), .wb_werf(wb_valid), .wb_value(wb_data),
        .rs1_value(id_rs1_value), .rs2_value(id_rs2_value)
    );

    assign id_operand_a = (id_op1_sel == zero) ? '0 : id_rs1_value;
    assign id_operand_b = (id_op2_sel == imm) ? id_imm : id_rs2_value;

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in || annul) begin
            ex_werf    <= 1'b0;
            ex_br_func <= none;
        end else begin
            ex_werf    <= id_werf;
            ex_br_func <= id_br_func;
        end
        ex_pc        <= id_pc;
        ex_br_target <= id_pc + id_imm;
        ex_rd        <= id_rd;
        ex_a         <= id_operand_a;
        ex_b         <= id_operand_b;
        ex_alu_func  <= id_alu_func;
        ex_wb_sel    <= id_wb_sel;
    end

    rv_alu u_alu (
        .alu_func(ex_alu_func), .br_func(ex_br_func), .a(ex_a), .b(ex_b),
        .result(ex_alu_result), .br_taken(ex_br_taken)
    );

    // JAL links pc+4
    assign ex_value = (ex_wb_sel == pc4) ? ex_pc + instr_step : ex_alu_result;

    ////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_werf;
        end
        wb_rd   <= ex_rd;
        wb_data <= ex_value;
    end

    // The bubble that follows a redirect can never redirect again
    a_no_back_to_back_annul: assert property (@(posedge clk_in) disable iff (rst_in)
        annul |=> !annul)
        else $error("annul asserted on two consecutive cycles");

endmodule

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int mem_words    = 128;
    localparam int max_tests    = 16;
    localparam int max_wb       = 64;
    localparam int drain_cycles = 12;

    logic     clk_in;
    logic     rst_in;
    word_t    imem_data;
    word_t    imem_addr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    word_t           imem [mem_words];
    bit              imem_loaded [mem_words];
    logic [8*24-1:0] test_name [max_tests];
    int              test_len [max_tests];
    reg_idx_t        exp_rd [max_wb];
    word_t           exp_data [max_wb];

    int num_tests, num_exp, prog_len;
    int wb_idx, test_idx, test_seen, test_errors;
    int pass_count, fail_count, error_count;
    int cycle_count, cycle_limit, drain;
    bit done, loaded;

    rv_core UUT (
        .clk_in(clk_in), .rst_in(rst_in), .imem_data(imem_data), .imem_addr(imem_addr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #20 clk_in = ~clk_in;

    ////////////////////////////////////////////////////////////
    // Trace loading
    ////////////////////////////////////////////////////////////

    task automatic load_trace(output bit ok);
        int              fd, code, n, i, idx;
        logic [8*24-1:0] tag;
        logic [8*24-1:0] name;
        logic [8*200-1:0] rest;
        word_t           addr, value, rd_word;
        ok = 1'b1;
        fd = $fopen("sim/rv_core_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/rv_core_trace.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    // Trailing blank space at the end of the file
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "I") begin
                    code = $fscanf(fd, "%h %d", addr, n);
                    for (i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%h", value);
                        idx = (addr / instr_step) + i;
                        if (idx >= mem_words) begin
                            $display("Program word at index %0d does not fit the memory", idx);
                            ok = 1'b0;
                        end else begin
                            imem[idx]        = value;
                            imem_loaded[idx] = 1'b1;
                            if (idx + 1 > prog_len) prog_len = idx + 1;
                        end
                    end
                end else if (tag == "T") begin
                    code = $fscanf(fd, "%s %d", name, n);
                    test_name[num_tests] = name;
                    test_len[num_tests]  = n;
                    num_tests++;
                end else if (tag == "W") begin
                    code = $fscanf(fd, "%h %h", rd_word, value);
                    exp_rd[num_exp]   = rd_word[reg_addr_w-1:0];
                    exp_data[num_exp] = value;
                    num_exp++;
                end else begin
                    $display("Unknown record %0s in the trace file", tag);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Instruction memory and writeback checking
    ////////////////////////////////////////////////////////////

    // Anything outside the loaded program fetches a no-op
    function automatic word_t fetch_word(input word_t addr);
        int idx;
        if ($isunknown(addr)) return nop_instr;
        idx = addr / instr_step;
        if (idx >= mem_words || !imem_loaded[idx]) return nop_instr;
        return imem[idx];
    endfunction

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Test %0s: pass (%0d writebacks)", test_name[test_idx], test_seen);
            pass_count++;
        end else begin
            $display("Test %0s: fail (%0d of %0d writebacks wrong)",
                     test_name[test_idx], test_errors, test_seen);
            fail_count++;
        end
        test_idx++;
        test_seen   = 0;
        test_errors = 0;
    endtask

    task automatic check_writeback();
        if (wb_idx >= num_exp) begin
            $display("Unexpected writeback of %h to x%0d at %0t after the last expected one",
                     wb_data, wb_rd, $time);
            error_count++;
        end else begin
            if (wb_rd !== exp_rd[wb_idx] || wb_data !== exp_data[wb_idx]) begin
                $display("Error at %0t: writeback %0d expected x%0d = %h, got x%0d = %h",
                         $time, wb_idx, exp_rd[wb_idx], exp_data[wb_idx], wb_rd, wb_data);
                test_errors++;
                error_count++;
            end
            wb_idx++;
            test_seen++;
            if (test_idx < num_tests && test_seen == test_len[test_idx]) begin
                finish_test();
            end
        end
    endtask

    // Inputs change on the falling edge only
    always @(negedge clk_in) begin
        imem_data = fetch_word(imem_addr);
    end

    always @(posedge clk_in) begin
        if (!rst_in && !done) begin
            cycle_count++;
            if (wb_valid === 1'b1) begin
                check_writeback();
            end
            // A few quiet cycles catch stray writes after the last record
            if (wb_idx >= num_exp) begin
                drain++;
                if (drain == drain_cycles) done = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (!done && cycle_count < cycle_limit) @(posedge clk_in);
        if (!done) begin
            $display("Writebacks stopped arriving: %0d of %0d seen after %0d cycles",
                     wb_idx, num_exp, cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        clk_in    = 1'b0;
        rst_in    = 1'b1;
        imem_data = nop_instr;
        total     = 0;
        load_trace(loaded);
        for (int t = 0; t < num_tests; t++) total += test_len[t];
        if (loaded && (total != num_exp || num_tests == 0)) begin
            $display("Trace test counts do not match its %0d writeback records", num_exp);
            loaded = 1'b0;
        end
        if (loaded) begin
            cycle_limit = 4 * prog_len + 50;
            repeat (4) @(posedge clk_in);
            @(negedge clk_in);
            rst_in = 1'b0;
            wait (done);
        end else begin
            error_count++;
        end
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, error_count);
        if (loaded && error_count == 0 && fail_count == 0 && pass_count == num_tests) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/rv_core_trace.txt ====
# I <byte address> <count> <words>   program words placed from that address on
# T <name> <count>, then W <rd> <value> per expected writeback, in program order
I 00 8 00500093 ffd00113 002081b3 40110233 001122b3 00113333 fff12393 fff0b413
I 20 8 00411493 01c15513 40115593 00109633 0014d6b3 4014d733 001177b3 00a0e833
I 40 1 0f00c893
I 44 5 00100913 01290933 012909b3 01390a33 412a0ab3
I 58 6 12345b37 00708013 abcde037 01600bb3 7ff06c13 fffffcb7
I 70 8 00f08663 fff00d93 fff00d93 001d0d13 00209663 fff00d93 fff00d93 001d0d13
I 90 8 00114663 fff00d93 fff00d93 001d0d13 0020d663 fff00d93 fff00d93 001d0d13
I b0 8 0020e663 fff00d93 fff00d93 001d0d13 00117663 fff00d93 fff00d93 001d0d13
I d0 6 00208663 001d0d13 001d0d13 0020f663 001d0d13 001d0d13
I e8 5 00c00e6f fff00d93 fff00d93 000e0eb3 0000006f
T alu_ops 17
W 01 00000005 W 02 fffffffd W 03 00000002 W 04 fffffff8 W 05 00000001
W 06 00000000 W 07 00000001 W 08 00000001 W 09 ffffffd0 W 0a 0000000f
W 0b fffffffe W 0c 000000a0 W 0d 07fffffe W 0e fffffffe W 0f 00000005
W 10 0000000f W 11 000000f5
T forwarding 5
W 12 00000001 W 12 00000002 W 13 00000004 W 14 00000006 W 15 00000004
T lui_and_x0 4
W 16 12345000 W 17 12345000 W 18 000007ff W 19 fffff000
T branches 10
W 1a 00000001 W 1a 00000002 W 1a 00000003 W 1a 00000004 W 1a 00000005
W 1a 00000006 W 1a 00000007 W 1a 00000008 W 1a 00000009 W 1a 0000000a
T jal_link 2
W 1c 000000ec W 1d 000000ec

// ==== filelist.f ====
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_forward_unit.sv
hdl/rv_core.sv
sim/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/rv_decoder.sv
      - hdl/rv_regfile.sv
      - hdl/rv_alu.sv
      - hdl/rv_forward_unit.sv
      - hdl/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_tb.sv
